// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cram_arb -f sources.f -o tb_cram_arb

run: compile
	./obj_dir/tb_cram_arb | tee $(LOG)
	grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: design/cram_arb.sv
// cellular-RAM port arbiter top; single clock, N_PORTS up to 8, ports below N_WR_PORTS take writes
`default_nettype none

module cram_arb #(
	parameter int N_PORTS    = 5,
	parameter int N_WR_PORTS = 3,
	parameter int CMD_DEPTH  = 4,
	parameter int WR_DEPTH   = 16
) (
	input  logic                                            mem_clk,
	input  logic                                            mem_rst_n,
	// client side
	input  logic [N_PORTS-1:0]                              port_cmd_en,
	input  logic [N_PORTS-1:0][cram_arb_pkg::instr_w-1:0]   port_cmd_instr,
	input  logic [N_PORTS-1:0][cram_arb_pkg::bl_w-1:0]      port_cmd_bl,
	input  logic [N_PORTS-1:0][cram_arb_pkg::addr_w-1:0]    port_cmd_addr,
	output logic [N_PORTS-1:0]                              port_cmd_full,
	input  logic [N_WR_PORTS-1:0]                           port_wr_en,
	input  logic [N_WR_PORTS-1:0][cram_arb_pkg::mask_w-1:0] port_wr_mask,
	input  logic [N_WR_PORTS-1:0][cram_arb_pkg::data_w-1:0] port_wr_data,
	output logic [N_WR_PORTS-1:0]                           port_wr_full,
	output logic [N_PORTS-1:0]                              port_rd_valid,
	output logic [cram_arb_pkg::data_w-1:0]                 port_rd_data,
	// controller side
	input  logic                                            init_done,
	output logic                                            mem_cmd_req,
	output logic [cram_arb_pkg::instr_w-1:0]                mem_cmd_instr,
	output logic [cram_arb_pkg::bl_w-1:0]                   mem_cmd_bl,
	output logic [cram_arb_pkg::addr_w-1:0]                 mem_cmd_byte_addr,
	output logic [cram_arb_pkg::master_w-1:0]               mem_cmd_master,
	input  logic                                            mem_cmd_ack,
	output logic [cram_arb_pkg::mask_w-1:0]                 mem_wr_mask,
	output logic [cram_arb_pkg::data_w-1:0]                 mem_wr_data,
	input  logic                                            mem_wr_ack,
	input  logic [cram_arb_pkg::master_w-1:0]               mem_wr_master,
	input  logic                                            mem_rd_req,
	input  logic [cram_arb_pkg::data_w-1:0]                 mem_rd_data,
	input  logic [cram_arb_pkg::master_w-1:0]               mem_rd_master
);

	cram_port_if port_if [N_PORTS] ();

	assign port_rd_data = mem_rd_data;	// broadcast, rd_valid marks the owner

	// --------------------
	// per-port queues
	// --------------------
	for (genvar i = 0; i < N_PORTS; i++)
	begin : g_port
		cram_arb_pkg::cmd_t cmd_in;

		assign cmd_in.instr     = port_cmd_instr[i];
		assign cmd_in.bl        = port_cmd_bl[i];
		assign cmd_in.byte_addr = port_cmd_addr[i];
		assign port_rd_valid[i] = port_if[i].rd_valid;

		cram_port_fifo #(
			.payload_t (cram_arb_pkg::cmd_t),
			.DEPTH     (CMD_DEPTH)
		) i_cmd_fifo (
			.mem_clk   (mem_clk),
			.mem_rst_n (mem_rst_n),
			.push      (port_cmd_en[i]),
			.push_data (cmd_in),
			.pop       (port_if[i].cmd_ack),
			.head      (port_if[i].cmd),
			.not_empty (port_if[i].cmd_req),	// request toward the arbiter
			.full      (port_cmd_full[i])
		);

		if (i < N_WR_PORTS)
		begin : g_wr
			cram_arb_pkg::wr_beat_t wr_in;

			assign wr_in.mask = port_wr_mask[i];
			assign wr_in.data = port_wr_data[i];

			cram_port_fifo #(
				.payload_t (cram_arb_pkg::wr_beat_t),
				.DEPTH     (WR_DEPTH)
			) i_wr_fifo (
				.mem_clk   (mem_clk),
				.mem_rst_n (mem_rst_n),
				.push      (port_wr_en[i]),
				.push_data (wr_in),
				.pop       (port_if[i].wr_ack),
				.head      (port_if[i].wr_beat),
				.not_empty (port_if[i].wr_valid),
				.full      (port_wr_full[i])
			);
		end
		else
		begin : g_rd
			assign port_if[i].wr_valid = 1'b0;	// read-only port, selector gives idle_mask
			assign port_if[i].wr_beat  = '0;
		end
	end

	cram_master_sel #(
		.N_PORTS (N_PORTS)
	) i_master_sel (
		.mem_clk           (mem_clk),
		.mem_rst_n         (mem_rst_n),
		.init_done         (init_done),
		.ports             (port_if),
		.mem_cmd_req       (mem_cmd_req),
		.mem_cmd_instr     (mem_cmd_instr),
		.mem_cmd_bl        (mem_cmd_bl),
		.mem_cmd_byte_addr (mem_cmd_byte_addr),
		.mem_cmd_master    (mem_cmd_master),
		.mem_cmd_ack       (mem_cmd_ack),
		.mem_wr_mask       (mem_wr_mask),
		.mem_wr_data       (mem_wr_data),
		.mem_wr_ack        (mem_wr_ack),
		.mem_wr_master     (mem_wr_master),
		.mem_rd_req        (mem_rd_req),
		.mem_rd_master     (mem_rd_master)
	);

endmodule

`default_nettype wire

// File: design/cram_arb_pkg.sv
// shared widths and payload types; master_w of 3 limits the arbiter to 8 ports
`default_nettype none

package cram_arb_pkg;

	// --------------------
	// field widths
	// --------------------
	localparam int addr_w   = 30;	// byte address
	localparam int data_w   = 32;	// one write or read word
	localparam int mask_w   = 4;	// one bit per byte lane
	localparam int bl_w     = 6;	// burst length field
	localparam int instr_w  = 3;	// controller instruction code
	localparam int master_w = 3;	// port number on the memory side

	// command queue entry, 39 bits
	typedef struct packed {
		logic [instr_w-1:0] instr;		// read / write code
		logic [bl_w-1:0]    bl;			// burst length
		logic [addr_w-1:0]  byte_addr;	// start address
	} cmd_t;

	// write queue entry, 36 bits
	typedef struct packed {
		logic [mask_w-1:0] mask;	// byte mask, 1 = lane masked
		logic [data_w-1:0] data;	// write word
	} wr_beat_t;

	// driven when the write master has no beat to give
	localparam logic [mask_w-1:0] idle_mask = '1;

endpackage

`default_nettype wire

// File: design/cram_master_sel.sv
// round-robin command grant for up to 8 ports; write and read steering follow the controller's master fields
`default_nettype none

module cram_master_sel #(
	parameter int N_PORTS = 5
) (
	input  logic                              mem_clk,
	input  logic                              mem_rst_n,
	input  logic                              init_done,	// controller ready
	cram_port_if.sel                          ports [N_PORTS],
	output logic                              mem_cmd_req,
	output logic [cram_arb_pkg::instr_w-1:0]  mem_cmd_instr,
	output logic [cram_arb_pkg::bl_w-1:0]     mem_cmd_bl,
	output logic [cram_arb_pkg::addr_w-1:0]   mem_cmd_byte_addr,
	output logic [cram_arb_pkg::master_w-1:0] mem_cmd_master,
	input  logic                              mem_cmd_ack,
	output logic [cram_arb_pkg::mask_w-1:0]   mem_wr_mask,
	output logic [cram_arb_pkg::data_w-1:0]   mem_wr_data,
	input  logic                              mem_wr_ack,
	input  logic [cram_arb_pkg::master_w-1:0] mem_wr_master,
	input  logic                              mem_rd_req,
	input  logic [cram_arb_pkg::master_w-1:0] mem_rd_master
);

	localparam int last_port = N_PORTS - 1;	// pointer start, so port 0 wins first

	logic [N_PORTS-1:0]                req_vec;		// per-port queue not empty
	cram_arb_pkg::cmd_t                cmd_arr [N_PORTS];
	logic [N_PORTS-1:0]                wr_valid_vec;
	cram_arb_pkg::wr_beat_t            wr_beat_arr [N_PORTS];
	logic [cram_arb_pkg::master_w-1:0] master_q;	// granted port
	logic [cram_arb_pkg::master_w-1:0] last_q;		// last port whose command completed
	logic [cram_arb_pkg::master_w-1:0] pick;		// next port in rotation
	logic                              req_q;		// command offered to controller
	logic                              any_req;
	cram_arb_pkg::cmd_t                cmd_out;
	cram_arb_pkg::wr_beat_t            wr_out;

	// --------------------
	// per-port steering
	// --------------------
	for (genvar i = 0; i < N_PORTS; i++)
	begin : g_port
		localparam logic [cram_arb_pkg::master_w-1:0] port_id = i;

		assign req_vec[i]       = ports[i].cmd_req;
		assign cmd_arr[i]       = ports[i].cmd;
		assign wr_valid_vec[i]  = ports[i].wr_valid;
		assign wr_beat_arr[i]   = ports[i].wr_beat;
		assign ports[i].cmd_ack  = req_q && mem_cmd_ack && (master_q == port_id);	// pop on handshake
		assign ports[i].wr_ack   = mem_wr_ack && (mem_wr_master == port_id);
		assign ports[i].rd_valid = mem_rd_req && (mem_rd_master == port_id);	// one-hot by master
	end

	assign any_req = |req_vec;

	// first requester after last_q, wrapping around
	always_comb
	begin
		int idx;
		pick = last_q;
		for (int k = N_PORTS; k >= 1; k--)
		begin
			idx = int'(last_q) + k;
			if (idx >= N_PORTS)
				idx = idx - N_PORTS;
			if (req_vec[idx])
				pick = idx[cram_arb_pkg::master_w-1:0];	// smallest distance wins
		end
	end

	// --------------------
	// grant register
	// --------------------
	always_ff @(posedge mem_clk or negedge mem_rst_n)
	begin
		if (!mem_rst_n)
		begin
			req_q    <= 1'b0;
			master_q <= '0;
			last_q   <= last_port[cram_arb_pkg::master_w-1:0];
		end
		else if (req_q)
		begin
			if (mem_cmd_ack || !init_done)
				req_q <= 1'b0;		// at least one idle cycle follows
			if (mem_cmd_ack)
				last_q <= master_q;	// rotation moves only on completion
		end
		else if (init_done && any_req)
		begin
			req_q    <= 1'b1;
			master_q <= pick;
		end
	end

	assign cmd_out           = cmd_arr[master_q];	// held stable by the queue head
	assign mem_cmd_req       = req_q;
	assign mem_cmd_instr     = cmd_out.instr;
	assign mem_cmd_bl        = cmd_out.bl;
	assign mem_cmd_byte_addr = cmd_out.byte_addr;
	assign mem_cmd_master    = master_q;

	// write beat mux, idle pattern when no beat is there
	always_comb
	begin
		wr_out.mask = cram_arb_pkg::idle_mask;
		wr_out.data = '0;
		for (int i = 0; i < N_PORTS; i++)
		begin
			if (wr_valid_vec[i] && (int'(mem_wr_master) == i))
				wr_out = wr_beat_arr[i];
		end
	end

	assign mem_wr_mask = wr_out.mask;
	assign mem_wr_data = wr_out.data;

endmodule

`default_nettype wire

// File: design/cram_port_fifo.sv
// single-clock queue, DEPTH of 2 or more; push into a full queue and pop of an empty one are dropped
`default_nettype none

module cram_port_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     mem_clk,
	input  logic     mem_rst_n,
	input  logic     push,			// write request from the client
	input  payload_t push_data,
	input  logic     pop,			// head consumed this cycle
	output payload_t head,			// oldest entry, valid while not_empty
	output logic     not_empty,
	output logic     full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t           store [DEPTH];	// no reset, guarded by count
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;		// entries held
	logic               do_push;
	logic               do_pop;

	assign do_push   = push && !full;		// drop when full
	assign do_pop    = pop && not_empty;	// ignore when empty
	assign full      = (count == DEPTH);
	assign not_empty = (count != '0);
	assign head      = store[rd_ptr];		// read straight from storage

	// --------------------
	// storage write
	// --------------------
	always_ff @(posedge mem_clk)
	begin
		if (do_push)
			store[wr_ptr] <= push_data;
	end

	// --------------------
	// pointers and count
	// --------------------
	always_ff @(posedge mem_clk or negedge mem_rst_n)
	begin
		if (!mem_rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;	// wrap at DEPTH
			if (do_pop)
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/cram_port_if.sv
// one client port as seen by the master selector; rd_valid is the only read-side signal
`default_nettype none

interface cram_port_if;

	// --------------------
	// command queue head
	// --------------------
	logic               cmd_req;	// queue not empty
	cram_arb_pkg::cmd_t cmd;		// head entry
	logic               cmd_ack;	// pop head

	// --------------------
	// write queue head
	// --------------------
	logic                   wr_valid;	// beat available
	cram_arb_pkg::wr_beat_t wr_beat;	// head beat
	logic                   wr_ack;		// pop head beat

	logic rd_valid;	// read word on the shared bus belongs here

	modport cmd_src (output cmd_req, output cmd, input cmd_ack);
	modport wr_src (output wr_valid, output wr_beat, input wr_ack);
	modport sel (
		input  cmd_req, input  cmd, output cmd_ack,
		input  wr_valid, input  wr_beat, output wr_ack,
		output rd_valid
	);

endinterface

`default_nettype wire

// File: sources.f
design/cram_arb_pkg.sv
design/cram_port_if.sv
design/cram_port_fifo.sv
design/cram_master_sel.sv
design/cram_arb.sv
tests/cram_arb_assertions.sv
tests/tb_cram_arb.sv

// File: tests/cram_arb_assertions.sv
// bound into every cram_arb; inputs are assumed to change away from the rising edge of mem_clk
`default_nettype none

module cram_arb_assertions #(
	parameter int N_PORTS = 5
) (
	input logic                              mem_clk,
	input logic                              mem_rst_n,
	input logic                              init_done,
	input logic                              mem_cmd_req,
	input logic                              mem_cmd_ack,
	input logic [cram_arb_pkg::instr_w-1:0]  mem_cmd_instr,
	input logic [cram_arb_pkg::bl_w-1:0]     mem_cmd_bl,
	input logic [cram_arb_pkg::addr_w-1:0]   mem_cmd_byte_addr,
	input logic [cram_arb_pkg::master_w-1:0] mem_cmd_master,
	input logic [N_PORTS-1:0]                port_rd_valid
);

	// --------------------
	// command handshake
	// --------------------
	a_init_low: assert property (@(posedge mem_clk) disable iff (!mem_rst_n)
		!$past(init_done) |-> !mem_cmd_req)	// controller not ready
		else $error("mem_cmd_req high one edge after init_done was low");

	a_cmd_stable: assert property (@(posedge mem_clk) disable iff (!mem_rst_n)
		mem_cmd_req && !mem_cmd_ack |=>
			$stable({mem_cmd_instr, mem_cmd_bl, mem_cmd_byte_addr, mem_cmd_master}))
		else $error("command fields changed while waiting for mem_cmd_ack");

	a_req_drop: assert property (@(posedge mem_clk) disable iff (!mem_rst_n)
		mem_cmd_req && mem_cmd_ack |=> !mem_cmd_req)	// one idle cycle after each transfer
		else $error("mem_cmd_req still high after the ack");

	a_rd_onehot: assert property (@(posedge mem_clk) disable iff (!mem_rst_n)
		$onehot0(port_rd_valid))
		else $error("more than one port_rd_valid bit high");

endmodule

bind cram_arb cram_arb_assertions #(.N_PORTS(N_PORTS)) i_cram_arb_assertions (.*);

`default_nettype wire

// File: tests/tb_cram_arb.sv
// default cram_arb parameters only; rows assume CMD_DEPTH 4 and port 3 as a read-only port
`default_nettype none

module tb_cram_arb;

	localparam int n_ports    = 5;
	localparam int n_wr       = 3;
	localparam int n_steps    = 36;
	localparam int max_cycles = 40 * n_steps + 5;	// reset plus 40 per row

	typedef enum logic [3:0] {k_cmd, k_wr, k_wack, k_rd, k_hold, k_init, k_idle, k_drain} kind_t;

	typedef struct packed {
		logic [3:0]  test;
		kind_t       kind;
		logic [2:0]  port;	// client port or controller master
		logic [2:0]  instr;
		logic [5:0]  bl;
		logic [7:0]  val;	// drop flag, level, cycles or grant count
		logic [31:0] exp;	// full flag, write mask, or grant order one nibble each
	} step_t;

	// --------------------
	// stimulus table
	// --------------------
	localparam step_t steps [n_steps] = '{
		'{1, k_cmd, 0, 1, 1, 0, 0},	// queued while init_done low
		'{1, k_cmd, 1, 2, 4, 0, 0},
		'{1, k_cmd, 2, 3, 8, 0, 0},
		'{1, k_cmd, 3, 4, 16, 0, 0},
		'{1, k_cmd, 4, 5, 32, 0, 0},
		'{1, k_idle, 0, 0, 0, 6, 0},	// no request yet
		'{1, k_init, 0, 0, 0, 1, 0},
		'{1, k_drain, 0, 0, 0, 5, 32'h43210},	// pointer starts at port 4
		'{2, k_cmd, 2, 6, 63, 0, 0},
		'{2, k_drain, 0, 0, 0, 1, 32'h2},
		'{3, k_hold, 0, 0, 0, 1, 0},
		'{3, k_cmd, 1, 0, 2, 0, 0},
		'{3, k_cmd, 1, 7, 3, 0, 0},
		'{3, k_cmd, 3, 1, 5, 0, 0},
		'{3, k_cmd, 3, 2, 9, 0, 0},
		'{3, k_hold, 0, 0, 0, 0, 0},
		'{3, k_drain, 0, 0, 0, 4, 32'h3131},	// alternating
		'{4, k_wr, 0, 0, 0, 0, 32'h0},
		'{4, k_wr, 1, 0, 0, 0, 32'h3},
		'{4, k_wr, 0, 0, 0, 0, 32'hc},
		'{4, k_wack, 1, 0, 0, 0, 0},
		'{4, k_wack, 0, 0, 0, 0, 0},
		'{4, k_wack, 0, 0, 0, 0, 0},
		'{4, k_wack, 3, 0, 0, 0, 0},	// read-only port
		'{4, k_wack, 0, 0, 0, 0, 0},	// drained queue
		'{5, k_rd, 0, 0, 0, 0, 0},
		'{5, k_rd, 4, 0, 0, 0, 0},
		'{6, k_hold, 0, 0, 0, 1, 0},
		'{6, k_cmd, 4, 1, 7, 0, 0},
		'{6, k_cmd, 4, 1, 7, 0, 0},
		'{6, k_cmd, 4, 1, 7, 0, 0},
		'{6, k_cmd, 4, 1, 7, 0, 1},	// queue now full
		'{6, k_cmd, 4, 1, 7, 1, 1},	// lost push
		'{6, k_hold, 0, 0, 0, 0, 0},
		'{6, k_drain, 0, 0, 0, 4, 32'h4444},
		'{6, k_idle, 0, 0, 0, 8, 0}	// nothing more from port 4
	};

	logic                                                 mem_clk = 1'b0;
	logic                                                 mem_rst_n;
	logic [n_ports-1:0]                                   port_cmd_en;
	logic [n_ports-1:0][cram_arb_pkg::instr_w-1:0]        port_cmd_instr;
	logic [n_ports-1:0][cram_arb_pkg::bl_w-1:0]           port_cmd_bl;
	logic [n_ports-1:0][cram_arb_pkg::addr_w-1:0]         port_cmd_addr;
	logic [n_ports-1:0]                                   port_cmd_full;
	logic [n_wr-1:0]                                      port_wr_en;
	logic [n_wr-1:0][cram_arb_pkg::mask_w-1:0]            port_wr_mask;
	logic [n_wr-1:0][cram_arb_pkg::data_w-1:0]            port_wr_data;
	logic [n_wr-1:0]                                      port_wr_full;
	logic [n_ports-1:0]                                   port_rd_valid;
	logic [cram_arb_pkg::data_w-1:0]                      port_rd_data;
	logic                                                 init_done;
	logic                                                 mem_cmd_req;
	logic [cram_arb_pkg::instr_w-1:0]                     mem_cmd_instr;
	logic [cram_arb_pkg::bl_w-1:0]                        mem_cmd_bl;
	logic [cram_arb_pkg::addr_w-1:0]                      mem_cmd_byte_addr;
	logic [cram_arb_pkg::master_w-1:0]                    mem_cmd_master;
	logic                                                 mem_cmd_ack = 1'b0;
	logic [cram_arb_pkg::mask_w-1:0]                      mem_wr_mask;
	logic [cram_arb_pkg::data_w-1:0]                      mem_wr_data;
	logic                                                 mem_wr_ack;
	logic [cram_arb_pkg::master_w-1:0]                    mem_wr_master;
	logic                                                 mem_rd_req;
	logic [cram_arb_pkg::data_w-1:0]                      mem_rd_data;
	logic [cram_arb_pkg::master_w-1:0]                    mem_rd_master;

	cram_arb_pkg::cmd_t                exp_cmd [n_ports][$];	// pushed, not yet granted
	cram_arb_pkg::wr_beat_t            exp_beat [n_wr][$];
	cram_arb_pkg::cmd_t                log_cmd [$];			// grant order seen by controller
	logic [cram_arb_pkg::master_w-1:0] log_master [$];
	logic                              hold_ack = 1'b0;
	int                                cycles = 0;
	int                                errors = 0;
	int                                test_errors = 0;
	int                                tests_run = 0;
	int                                tests_failed = 0;

	cram_arb i_cram_arb (.*);

	always #4 mem_clk = ~mem_clk;

	always @(posedge mem_clk)
	begin
		cycles = cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("timeout after %0d cycles, a wait never ended", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// controller model, acks on first sight of a request
	always @(posedge mem_clk)
	begin
		#1;
		if (mem_cmd_req && !mem_cmd_ack && !hold_ack)
		begin
			mem_cmd_ack = 1'b1;
			log_master.push_back(mem_cmd_master);
			log_cmd.push_back({mem_cmd_instr, mem_cmd_bl, mem_cmd_byte_addr});
		end
		else
			mem_cmd_ack = 1'b0;
	end

	task automatic next_cycle();
		@(posedge mem_clk);
		#1;	// drive point
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("FAILED %s: got %h, expected %h", name, got, want);
		test_errors++;
	endtask

	task automatic report_problem(input string what);
		$display("error: %s", what);
		test_errors++;
	endtask

	task automatic report_test(input int t);
		tests_run++;
		if (test_errors == 0)
			$display("test %0d done, ok", t);
		else
		begin
			$display("test %0d done, %0d errors", t, test_errors);
			tests_failed++;
		end
		errors += test_errors;
		test_errors = 0;
	endtask

	// next logged grant against expected port and that port's oldest command
	task automatic check_grant(input int want);
		int                 got;
		cram_arb_pkg::cmd_t c_got;
		cram_arb_pkg::cmd_t c_exp;
		got = int'(log_master.pop_front());
		c_got = log_cmd.pop_front();
		if (got != want)
			report_mismatch("mem_cmd_master", got, want);
		else if (exp_cmd[got].size() == 0)
			report_problem("command granted on a port with nothing queued");
		else
		begin
			c_exp = exp_cmd[got].pop_front();
			if (c_got.instr !== c_exp.instr)
				report_mismatch("mem_cmd_instr", c_got.instr, c_exp.instr);
			if (c_got.bl !== c_exp.bl)
				report_mismatch("mem_cmd_bl", c_got.bl, c_exp.bl);
			if (c_got.byte_addr !== c_exp.byte_addr)
				report_mismatch("mem_cmd_byte_addr", c_got.byte_addr, c_exp.byte_addr);
		end
	endtask

	task automatic apply_step(input step_t st);
		cram_arb_pkg::cmd_t     c;
		cram_arb_pkg::wr_beat_t b;
		logic [31:0]            rnd;
		logic [n_ports-1:0]     onehot;
		int                     p;
		p = int'(st.port);
		rnd = $urandom();
		case (st.kind)
			k_cmd:
			begin
				c.instr = st.instr;
				c.bl = st.bl;
				c.byte_addr = rnd[29:0];
				port_cmd_instr[p] = c.instr;
				port_cmd_bl[p] = c.bl;
				port_cmd_addr[p] = c.byte_addr;
				port_cmd_en[p] = 1'b1;
				next_cycle();
				port_cmd_en[p] = 1'b0;
				if (!st.val[0])
					exp_cmd[p].push_back(c);	// lost pushes never come out
				if (port_cmd_full[p] !== st.exp[0])
					report_mismatch("port_cmd_full", port_cmd_full[p], st.exp[0]);
			end
			k_wr:
			begin
				b.mask = st.exp[3:0];
				b.data = rnd;
				port_wr_mask[p] = b.mask;
				port_wr_data[p] = b.data;
				port_wr_en[p] = 1'b1;
				next_cycle();
				port_wr_en[p] = 1'b0;
				exp_beat[p].push_back(b);
			end
			k_wack:
			begin
				b.mask = cram_arb_pkg::idle_mask;	// no beat there
				b.data = '0;
				if (p < n_wr && exp_beat[p].size() > 0)
					b = exp_beat[p].pop_front();
				mem_wr_master = st.port;
				mem_wr_ack = 1'b1;
				#3;	// mid-cycle sample
				if (mem_wr_mask !== b.mask)
					report_mismatch("mem_wr_mask", mem_wr_mask, b.mask);
				if (mem_wr_data !== b.data)
					report_mismatch("mem_wr_data", mem_wr_data, b.data);
				next_cycle();
				mem_wr_ack = 1'b0;
			end
			k_rd:
			begin
				onehot = '0;
				onehot[p] = 1'b1;
				mem_rd_master = st.port;
				mem_rd_data = rnd;
				mem_rd_req = 1'b1;
				#3;
				if (port_rd_valid !== onehot)
					report_mismatch("port_rd_valid", port_rd_valid, onehot);
				if (port_rd_data !== rnd)
					report_mismatch("port_rd_data", port_rd_data, rnd);
				next_cycle();
				mem_rd_req = 1'b0;
			end
			k_hold:
			begin
				hold_ack <= st.val[0];	// seen by the model from the next cycle
				next_cycle();
			end
			k_init:
			begin
				init_done = st.val[0];
				next_cycle();
			end
			k_idle:
			begin
				repeat (st.val)
				begin
					next_cycle();
					if (!init_done && mem_cmd_req)
						report_problem("mem_cmd_req raised while init_done is low");
				end
				if (log_master.size() != 0)
					report_problem("controller saw a command that was not expected");
			end
			default:
			begin
				while (log_master.size() < int'(st.val))
				begin
					@(posedge mem_clk);
					#2;	// after the model's update
				end
				next_cycle();	// last handshake done
				for (int i = 0; i < int'(st.val); i++)
					check_grant(int'(st.exp[4*i +: 4]));
			end
		endcase
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial
	begin
		void'($urandom(32'h82f7b445));
		mem_rst_n      = 1'b0;
		init_done      = 1'b0;	// controller still calibrating
		port_cmd_en    = '0;
		port_cmd_instr = '0;
		port_cmd_bl    = '0;
		port_cmd_addr  = '0;
		port_wr_en     = '0;
		port_wr_mask   = '0;
		port_wr_data   = '0;
		mem_wr_ack     = 1'b0;
		mem_wr_master  = '0;
		mem_rd_req     = 1'b0;
		mem_rd_data    = '0;
		mem_rd_master  = '0;
		repeat (5) @(posedge mem_clk);
		#1;
		mem_rst_n = 1'b1;
		if (mem_cmd_req !== 1'b0)
			report_mismatch("mem_cmd_req", mem_cmd_req, 0);
		if (port_rd_valid !== '0)
			report_mismatch("port_rd_valid", port_rd_valid, 0);
		if (port_cmd_full !== '0)
			report_mismatch("port_cmd_full", port_cmd_full, 0);
		if (port_wr_full !== '0)
			report_mismatch("port_wr_full", port_wr_full, 0);
		report_test(0);
		for (int s = 0; s < n_steps; s++)
		begin
			apply_step(steps[s]);
			if (s == n_steps - 1 || steps[s + 1].test != steps[s].test)
				report_test(int'(steps[s].test));
		end
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
